// ==== rv_core_defines.svh ====
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

`define RV_RESET_PC     32'h0000_0000
`define RV_NREGS        16

// major opcodes
`define RV_OPC_LUI      7'b0110111
`define RV_OPC_OPIMM    7'b0010011
`define RV_OPC_OP       7'b0110011
`define RV_OPC_LOAD     7'b0000011
`define RV_OPC_STORE    7'b0100011
`define RV_OPC_BRANCH   7'b1100011
`define RV_OPC_JAL      7'b1101111
`define RV_OPC_SYSTEM   7'b1110011

`define RV_F3_ADD       3'b000
`define RV_F3_SLT       3'b010
`define RV_F3_XOR       3'b100
`define RV_F3_OR        3'b110
`define RV_F3_AND       3'b111
`define RV_F3_LW        3'b010
`define RV_F3_LBU       3'b100
`define RV_F3_SW        3'b010
`define RV_F3_BEQ       3'b000
`define RV_F3_BNE       3'b001

`define RV_F7_BASE      7'b0000000
`define RV_F7_SUB       7'b0100000

`endif

// ==== rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    typedef enum logic [4:0] {
        op_lui,
        op_addi,
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_lw,
        op_lbu,
        op_sw,
        op_beq,
        op_bne,
        op_jal,
        op_ebreak,
        op_illegal
    } rv_op_e;

    typedef enum logic [2:0] {
        st_fetch,
        st_exec,
        st_mem,
        st_wb,
        st_halt
    } rv_state_e;

    typedef struct packed {
        rv_op_e      op;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic [3:0]  rd;
        logic [31:0] imm;
        logic        wr_rd;
        logic        is_load;
        logic        is_store;
    } rv_dec_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        we;
    } rv_mem_req_t;

endpackage

`default_nettype wire

// ==== rv_idu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defines.svh"

module rv_idu
    import rv_core_pkg::*;
(
    input  logic [31:0] inst,
    output rv_dec_t     dec
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        use_rs1;
    logic        use_rs2;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        dec     = '0;
        dec.op  = op_illegal;
        dec.rs1 = inst[18:15];
        dec.rs2 = inst[23:20];
        dec.rd  = inst[10:7];
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            `RV_OPC_LUI: begin
                dec.op    = op_lui;
                dec.imm   = {inst[31:12], 12'h000};
                dec.wr_rd = 1'b1;
            end
            `RV_OPC_OPIMM: begin
                dec.op    = (funct3 == `RV_F3_ADD) ? op_addi : op_illegal;
                dec.imm   = imm_i;
                dec.wr_rd = 1'b1;
                use_rs1   = 1'b1;
            end
            `RV_OPC_OP: begin
                dec.wr_rd = 1'b1;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                case ({funct7, funct3})
                    {`RV_F7_BASE, `RV_F3_ADD}: dec.op = op_add;
                    {`RV_F7_SUB, `RV_F3_ADD}:  dec.op = op_sub;
                    {`RV_F7_BASE, `RV_F3_AND}: dec.op = op_and;
                    {`RV_F7_BASE, `RV_F3_OR}:  dec.op = op_or;
                    {`RV_F7_BASE, `RV_F3_XOR}: dec.op = op_xor;
                    {`RV_F7_BASE, `RV_F3_SLT}: dec.op = op_slt;
                    default:                   dec.op = op_illegal;
                endcase
            end
            `RV_OPC_LOAD: begin
                if (funct3 == `RV_F3_LW) begin
                    dec.op = op_lw;
                end else if (funct3 == `RV_F3_LBU) begin
                    dec.op = op_lbu;
                end
                dec.imm     = imm_i;
                dec.wr_rd   = 1'b1;
                dec.is_load = 1'b1;
                use_rs1     = 1'b1;
            end
            `RV_OPC_STORE: begin
                dec.op       = (funct3 == `RV_F3_SW) ? op_sw : op_illegal;
                dec.imm      = imm_s;
                dec.is_store = 1'b1;
                use_rs1      = 1'b1;
                use_rs2      = 1'b1;
            end
            `RV_OPC_BRANCH: begin
                if (funct3 == `RV_F3_BEQ) begin
                    dec.op = op_beq;
                end else if (funct3 == `RV_F3_BNE) begin
                    dec.op = op_bne;
                end
                dec.imm = imm_b;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            `RV_OPC_JAL: begin
                dec.op    = op_jal;
                dec.imm   = imm_j;
                dec.wr_rd = 1'b1;
            end
            `RV_OPC_SYSTEM: begin
                // only the exact ebreak encoding
                if (inst[31:20] == 12'h001 && inst[19:7] == '0) begin
                    dec.op = op_ebreak;
                end
            end
            default: dec.op = op_illegal;
        endcase

        // rv32e has x0..x15 only
        if (dec.op == op_illegal || (dec.wr_rd && inst[11]) ||
            (use_rs1 && inst[19]) || (use_rs2 && inst[24])) begin
            dec.op       = op_illegal;
            dec.wr_rd    = 1'b0;
            dec.is_load  = 1'b0;
            dec.is_store = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defines.svh"

module rv_regfile
    import rv_core_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  logic        we,
    input  logic [3:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [3:0]  raddr1,
    input  logic [3:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [`RV_NREGS];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 4'd0) begin  // x0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

// ==== rv_exu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_exu
    import rv_core_pkg::*;
(
    input  rv_dec_t     dec,
    input  logic [31:0] pc,
    input  logic [31:0] rs1_val,
    input  logic [31:0] rs2_val,
    output logic [31:0] alu_out,
    output logic        taken
);

    logic [31:0] sum_imm;
    logic [31:0] pc_plus4;

    assign sum_imm  = rs1_val + dec.imm;
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        // cleared inst register decodes as illegal, so this is the fetch address
        alu_out = pc;
        taken   = 1'b0;
        case (dec.op)
            op_lui:  alu_out = dec.imm;
            op_addi: alu_out = sum_imm;
            op_add:  alu_out = rs1_val + rs2_val;
            op_sub:  alu_out = rs1_val - rs2_val;
            op_and:  alu_out = rs1_val & rs2_val;
            op_or:   alu_out = rs1_val | rs2_val;
            op_xor:  alu_out = rs1_val ^ rs2_val;
            op_slt:  alu_out = {31'd0, $signed(rs1_val) < $signed(rs2_val)};
            op_lw, op_lbu, op_sw: begin
                alu_out = sum_imm;  // effective address
            end
            op_beq:  taken = (rs1_val == rs2_val);
            op_bne:  taken = (rs1_val != rs2_val);
            op_jal: begin
                alu_out = pc_plus4;  // link
                taken   = 1'b1;
            end
            default: alu_out = pc;
        endcase
    end

endmodule

`default_nettype wire

// ==== rv_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_lsu
    import rv_core_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  logic        start,
    input  logic        is_fetch,
    input  rv_dec_t     dec,
    input  logic [31:0] addr,
    input  logic [31:0] store_val,
    input  logic        mem_ack,
    input  logic [31:0] mem_rdata,
    output logic        done,
    output logic [31:0] rdata,
    output logic        mem_req,
    output rv_mem_req_t mem_pkt
);

    typedef enum logic [1:0] {
        ls_idle,
        ls_req,
        ls_rel
    } ls_state_e;

    ls_state_e  ls_state;
    logic       data_store;
    logic       byte_ld;
    logic [1:0] byte_off;

    assign data_store = !is_fetch && dec.is_store;
    assign mem_req    = (ls_state == ls_req);
    assign done       = (ls_state == ls_rel) && !mem_ack;  // ack released

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ls_state <= ls_idle;
        end else begin
            case (ls_state)
                ls_idle: if (start) ls_state <= ls_req;
                ls_req:  if (mem_ack) ls_state <= ls_rel;
                ls_rel:  if (!mem_ack) ls_state <= ls_idle;
                default: ls_state <= ls_idle;
            endcase
        end
    end

    // request held stable for the whole handshake
    always_ff @(posedge clock) begin
        if (ls_state == ls_idle && start) begin
            mem_pkt.addr  <= {addr[31:2], 2'b00};
            mem_pkt.wdata <= data_store ? store_val : 32'd0;
            mem_pkt.wstrb <= data_store ? 4'b1111 : 4'b0000;
            mem_pkt.we    <= data_store;
            byte_ld       <= !is_fetch && (dec.op == op_lbu);
            byte_off      <= addr[1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (ls_state == ls_req && mem_ack) begin
            rdata <= byte_ld ? {24'd0, mem_rdata[{byte_off, 3'b000} +: 8]} : mem_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== rv_commit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defines.svh"

module rv_commit
    import rv_core_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  rv_dec_t     dec,
    input  logic [31:0] alu_out,
    input  logic        taken,
    input  logic        lsu_done,
    input  logic [31:0] lsu_rdata,
    output rv_state_e   state,
    output logic        lsu_start,
    output logic        lsu_is_fetch,
    output logic [31:0] inst,
    output logic [31:0] pc,
    output logic        rf_we,
    output logic [31:0] rf_wdata,
    output logic        halted,
    output logic        illegal
);

    logic [31:0] pc_next;

    assign pc_next      = taken ? pc + dec.imm : pc + 32'd4;
    assign lsu_is_fetch = (state == st_fetch);
    assign lsu_start    = (state == st_fetch) || (state == st_mem);  // lsu takes it when idle
    assign rf_we        = (state == st_wb) && dec.wr_rd;
    assign rf_wdata     = dec.is_load ? lsu_rdata : alu_out;
    assign halted       = (state == st_halt);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state   <= st_fetch;
            pc      <= `RV_RESET_PC;
            inst    <= '0;
            illegal <= 1'b0;
        end else begin
            case (state)
                st_fetch: if (lsu_done) begin
                    inst  <= lsu_rdata;
                    state <= st_exec;
                end
                st_exec: begin
                    if (dec.op == op_ebreak || dec.op == op_illegal) begin
                        illegal <= (dec.op == op_illegal);
                        state   <= st_halt;
                    end else if (dec.is_load || dec.is_store) begin
                        state <= st_mem;
                    end else begin
                        state <= st_wb;
                    end
                end
                st_mem:  if (lsu_done) state <= st_wb;
                st_wb: begin
                    pc    <= pc_next;
                    inst  <= '0;  // empty inst steers alu_out to pc
                    state <= st_fetch;
                end
                st_halt: state <= st_halt;
                default: state <= st_halt;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core
    import rv_core_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  logic        mem_ack,
    input  logic [31:0] mem_rdata,
    output logic        mem_req,
    output rv_mem_req_t mem_pkt,
    output logic [31:0] pc,
    output logic        halted,
    output logic        illegal
);

    rv_dec_t     dec;
    logic [31:0] inst;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] alu_out;
    logic        taken;
    logic        lsu_start;
    logic        lsu_is_fetch;
    logic        lsu_done;
    logic [31:0] lsu_rdata;
    logic        rf_we;
    logic [31:0] rf_wdata;

    rv_idu u_idu (
        .inst (inst),
        .dec  (dec)
    );

    rv_regfile u_regfile (
        .clock  (clock),
        .rst_n  (rst_n),
        .we     (rf_we),
        .waddr  (dec.rd),
        .wdata  (rf_wdata),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val)
    );

    rv_exu u_exu (
        .dec     (dec),
        .pc      (pc),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .alu_out (alu_out),
        .taken   (taken)
    );

    rv_lsu u_lsu (
        .clock     (clock),
        .rst_n     (rst_n),
        .start     (lsu_start),
        .is_fetch  (lsu_is_fetch),
        .dec       (dec),
        .addr      (alu_out),
        .store_val (rs2_val),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .done      (lsu_done),
        .rdata     (lsu_rdata),
        .mem_req   (mem_req),
        .mem_pkt   (mem_pkt)
    );

    rv_commit u_commit (
        .clock        (clock),
        .rst_n        (rst_n),
        .dec          (dec),
        .alu_out      (alu_out),
        .taken        (taken),
        .lsu_done     (lsu_done),
        .lsu_rdata    (lsu_rdata),
        .state        (),
        .lsu_start    (lsu_start),
        .lsu_is_fetch (lsu_is_fetch),
        .inst         (inst),
        .pc           (pc),
        .rf_we        (rf_we),
        .rf_wdata     (rf_wdata),
        .halted       (halted),
        .illegal      (illegal)
    );

endmodule

`default_nettype wire

// ==== rv_core_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_assertions
    import rv_core_pkg::*;
(
    input logic        clock,
    input logic        rst_n,
    input logic        mem_req,
    input logic        mem_ack,
    input rv_mem_req_t mem_pkt,
    input logic        halted
);

    // request must not move until the memory answers
    pkt_stable: assert property (@(posedge clock) disable iff (!rst_n)
        (mem_req && !mem_ack) |=> $stable(mem_pkt))
        else $error("mem_pkt changed during an open request");

    req_after_release: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(mem_req) |-> !mem_ack)
        else $error("mem_req raised while mem_ack still high");

    reset_quiet: assert property (@(posedge clock)
        !rst_n |=> (!mem_req && !halted))
        else $error("mem_req or halted high right after reset");

endmodule

bind rv_core rv_core_assertions u_assertions (
    .clock   (clock),
    .rst_n   (rst_n),
    .mem_req (mem_req),
    .mem_ack (mem_ack),
    .mem_pkt (mem_pkt),
    .halted  (halted)
);

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;  // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clock);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_core_defines.svh"

module tb_rv_core
    import rv_core_pkg::*;
;

    localparam int CYCLE_LIMIT = 20000;

    logic        clock;
    logic        gen_rst_n;
    logic        run_en;
    logic        mem_ack;
    logic [31:0] mem_rdata;
    logic        mem_req;
    rv_mem_req_t mem_pkt;
    logic [31:0] pc;
    logic        halted;
    logic        illegal;

    logic [31:0] mem [0:1023];
    logic [31:0] seed;
    logic        rand_delay;
    logic        in_req;
    logic [1:0]  wait_cnt;
    int          cycles;
    int          load_idx;

    tb_clock_gen u_clk (.clock(clock), .rst_n(gen_rst_n));

    rv_core DUT (
        .clock     (clock),
        .rst_n     (gen_rst_n && run_en),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .mem_pkt   (mem_pkt),
        .pc        (pc),
        .halted    (halted),
        .illegal   (illegal)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // memory side of the four-phase handshake
    always @(posedge clock) begin
        if (!(gen_rst_n && run_en)) begin
            mem_ack <= 1'b0;
            in_req  <= 1'b0;
        end else if (mem_req && !mem_ack) begin
            if (!in_req) begin
                in_req   <= 1'b1;
                wait_cnt <= rand_delay ? seed[1:0] : 2'd0;
                seed     <= xorshift32(seed);
            end else if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else begin
                mem_ack   <= 1'b1;
                mem_rdata <= mem[mem_pkt.addr[11:2]];
                in_req    <= 1'b0;
                for (int b = 0; b < 4; b++) begin
                    if (mem_pkt.we && mem_pkt.wstrb[b])
                        mem[mem_pkt.addr[11:2]][8*b +: 8] = mem_pkt.wdata[8*b +: 8];
                end
            end
        end else if (mem_ack && !mem_req) begin
            mem_ack <= 1'b0;
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the core did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // instruction encoders
    function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [31:0] imm);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [31:0] imm);
        return {imm[11:5], rs2, 5'd0, `RV_F3_SW, imm[4:0], `RV_OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [31:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OPC_JAL};
    endfunction

    task automatic emit(input logic [31:0] w);
        mem[load_idx] = w;
        load_idx++;
    endtask

    // hold the core in reset and refill memory
    task automatic start_load();
        @(posedge clock);
        run_en <= 1'b0;
        repeat (4) @(posedge clock);
        for (int i = 0; i < 1024; i++)
            mem[i] = {i[15:0] ^ 16'h5a5a, ~i[15:0]};
        load_idx = 0;
    endtask

    task automatic run_to_halt();
        @(posedge clock);
        run_en <= 1'b1;
        @(negedge clock);
        while (!halted) @(negedge clock);
    endtask

    task automatic arith_program();
        emit({20'h12345, 5'd1, `RV_OPC_LUI});
        emit(enc_i(`RV_OPC_OPIMM, `RV_F3_ADD, 1, 1, 32'h678));
        emit(enc_i(`RV_OPC_OPIMM, `RV_F3_ADD, 2, 0, -5));
        emit(enc_r(`RV_F7_BASE, `RV_F3_ADD, 3, 1, 2));
        emit(enc_r(`RV_F7_SUB, `RV_F3_ADD, 4, 1, 2));
        emit(enc_r(`RV_F7_BASE, `RV_F3_AND, 5, 1, 2));
        emit(enc_r(`RV_F7_BASE, `RV_F3_OR, 6, 1, 2));
        emit(enc_r(`RV_F7_BASE, `RV_F3_XOR, 7, 1, 2));
        emit(enc_r(`RV_F7_BASE, `RV_F3_SLT, 8, 2, 1));
        emit(enc_r(`RV_F7_BASE, `RV_F3_SLT, 9, 1, 2));
        for (int r = 1; r <= 9; r++)
            emit(enc_sw(r[4:0], 32'h100 + 4 * (r - 1)));
        emit(32'h0010_0073);  // ebreak
    endtask

    task automatic check_arith();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] exp [9];
        a = 32'h1234_5678;
        b = -32'sd5;
        exp = '{a, b, a + b, a - b, a & b, a | b, a ^ b, 32'd1, 32'd0};
        for (int k = 0; k < 9; k++)
            check_value($sformatf("mem[0x%0h]", 256 + 4 * k), exp[k], mem[64 + k]);
        check_value("pc", 32'd4 * (load_idx - 1), pc);
        check_value("illegal", 32'd0, {31'd0, illegal});
    endtask

    task automatic test_arith();
        start_load();
        arith_program();
        run_to_halt();
        check_arith();
    endtask

    task automatic test_load_store();
        start_load();
        emit({20'hA1B2C, 5'd2, `RV_OPC_LUI});
        emit(enc_i(`RV_OPC_OPIMM, `RV_F3_ADD, 2, 2, 32'h3D4));
        emit(enc_sw(2, 32'h200));
        for (int k = 0; k < 4; k++)
            emit(enc_i(`RV_OPC_LOAD, `RV_F3_LBU, 3 + k, 0, 32'h200 + k));
        emit(enc_i(`RV_OPC_LOAD, `RV_F3_LW, 7, 0, 32'h200));
        for (int k = 0; k < 5; k++)
            emit(enc_sw(3 + k, 32'h204 + 4 * k));
        emit(32'h0010_0073);
        run_to_halt();
        check_value("mem[0x200]", 32'hA1B2_C3D4, mem[128]);
        check_value("lbu byte0", 32'h0000_00D4, mem[129]);
        check_value("lbu byte1", 32'h0000_00C3, mem[130]);
        check_value("lbu byte2", 32'h0000_00B2, mem[131]);
        check_value("lbu byte3", 32'h0000_00A1, mem[132]);
        check_value("lw word", 32'hA1B2_C3D4, mem[133]);
    endtask

    task automatic test_control_flow();
        start_load();
        emit(enc_i(`RV_OPC_OPIMM, `RV_F3_ADD, 1, 0, 5));   // loop count
        emit(enc_i(`RV_OPC_OPIMM, `RV_F3_ADD, 2, 0, 0));
        emit(enc_i(`RV_OPC_OPIMM, `RV_F3_ADD, 2, 2, 1));   // 0x08 loop
        emit(enc_i(`RV_OPC_OPIMM, `RV_F3_ADD, 1, 1, -1));
        emit(enc_b(`RV_F3_BNE, 1, 0, -8));
        emit(enc_b(`RV_F3_BEQ, 0, 0, 8));
        emit(enc_i(`RV_OPC_OPIMM, `RV_F3_ADD, 2, 0, 99));  // skipped
        emit(enc_j(5, 16));                                 // 0x1c call
        emit(enc_sw(2, 32'h300));
        emit(enc_sw(5, 32'h304));
        emit(32'h0010_0073);
        emit(enc_j(0, -12));                                // 0x2c return
        run_to_halt();
        check_value("loop count", 32'd5, mem[192]);
        check_value("jal link", 32'h1c + 32'd4, mem[193]);
        check_value("pc", 32'h28, pc);
    endtask

    task automatic test_random_ack();
        rand_delay = 1'b1;
        test_arith();
        rand_delay = 1'b0;
    endtask

    task automatic test_x0_illegal();
        start_load();
        emit(enc_i(`RV_OPC_OPIMM, `RV_F3_ADD, 0, 0, 7));
        emit(enc_sw(0, 32'h400));
        emit(32'h0000_007f);  // unknown opcode
        run_to_halt();
        check_value("mem[0x400]", 32'd0, mem[256]);
        check_value("illegal", 32'd1, {31'd0, illegal});
        check_value("pc", 32'd8, pc);
        repeat (10) begin
            @(negedge clock);
            check_value("mem_req", 32'd0, {31'd0, mem_req});
            check_value("halted", 32'd1, {31'd0, halted});
        end
    endtask

    initial begin
        run_en     = 1'b0;
        mem_ack    = 1'b0;
        mem_rdata  = 32'd0;
        rand_delay = 1'b0;
        in_req     = 1'b0;
        wait_cnt   = 2'd0;
        seed       = 32'h906d;
        cycles     = 0;
        load_idx   = 0;
        @(posedge gen_rst_n);
        test_arith();
        test_load_store();
        test_control_flow();
        test_random_ack();
        test_x0_illegal();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
rv_core_pkg.sv
rv_idu.sv
rv_regfile.sv
rv_exu.sv
rv_lsu.sv
rv_commit.sv
rv_core.sv
rv_core_assertions.sv
tb_clock_gen.sv
tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module tb_rv_core -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED"
